/* bench/sram_model.sv */
`default_nettype none

// Behavioral synchronous single-port RAM
// Byte write enables, read data one cycle after the select
module sram_model
   import ahb_sram_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       cs,      // Active high
   input  wire lanes_t     wen,     // Per byte, active high
   input  wire word_addr_t addr,
   input  wire data_t      wdata,
   output data_t           rdata
);

   localparam int WORDS = 1 << WORD_ADDR_W;

   data_t mem [0:WORDS-1];

   // Power-up fill built from every address bit of the word
   initial
   begin
      for (int i = 0; i < WORDS; i++)
         mem[i] = {2'b10, word_addr_t'(i), 2'b01, ~word_addr_t'(i)};
   end

   always @(posedge clk)
   begin
      if (cs)
      begin
         for (int i = 0; i < LANES; i++)
            if (wen[i])
               mem[addr][8*i +: 8] = wdata[8*i +: 8];   // Enabled byte only
         if (wen == '0)
            rdata <= mem[addr];                      // Read cycle
      end
   end

endmodule

`default_nettype wire

/* bench/tb_ahb_to_sram.sv */
`default_nettype none

module tb_ahb_to_sram
   import ahb_sram_pkg::*;
();

   localparam int     CLK_PERIOD  = 40;
   localparam int     DRIVE_DELAY = 5;             // Inputs change after the rising edge
   localparam int     WORDS       = 1 << WORD_ADDR_W;
   localparam int     N_RANDOM    = 400;
   localparam haddr_t RAND_BASE   = 16'h0200;      // Eight words for the random mix
   // Cycle budget per test in the order idle, word, lanes, merge, random
   localparam int     TOTAL_CYCLES  = 10 + 12 + 70 + 30 + (N_RANDOM + 10);
   localparam int     WATCHDOG_TIME = (TOTAL_CYCLES + 50) * CLK_PERIOD;

   logic HCLK = 1'b0;
   logic HRESETn, HSEL, HREADY, HWRITE;
   htrans_t HTRANS;
   hsize_t HSIZE;
   haddr_t HADDR;
   data_t HWDATA, HRDATA, SRAMRDATA, SRAMWDATA;
   logic HREADYOUT, HRESP, SRAMCS;
   lanes_t SRAMWEN;
   word_addr_t SRAMADDR;

   data_t       ref_mem [0:WORDS-1];    // Expected RAM contents
   data_t       next_wdata;             // HWDATA for the next cycle
   logic [31:0] lfsr_state;
   int          errors, checks, checks_mark, errors_mark, tests_done;

   // Monitor pipeline holds the previous address phase and the owed RAM write
   logic       rd_dphase, wr_dphase, owe;
   word_addr_t rd_addr, wr_addr, owe_addr;
   lanes_t     wr_lanes, owe_lanes;
   data_t      owe_data;

   always #(CLK_PERIOD/2) HCLK = ~HCLK;

   ahb_to_sram dut (
      .HCLK (HCLK), .HRESETn (HRESETn),
      .HSEL (HSEL), .HREADY (HREADY), .HTRANS (HTRANS), .HSIZE (HSIZE),
      .HWRITE (HWRITE), .HADDR (HADDR), .HWDATA (HWDATA),
      .HREADYOUT (HREADYOUT), .HRESP (HRESP), .HRDATA (HRDATA),
      .SRAMRDATA (SRAMRDATA), .SRAMADDR (SRAMADDR), .SRAMWEN (SRAMWEN),
      .SRAMWDATA (SRAMWDATA), .SRAMCS (SRAMCS)
   );

   sram_model u_sram (
      .clk (HCLK), .cs (SRAMCS), .wen (SRAMWEN), .addr (SRAMADDR),
      .wdata (SRAMWDATA), .rdata (SRAMRDATA)
   );

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------
   function automatic lanes_t size_to_lanes(input hsize_t size, input logic [1:0] lo);
      case (size)
         HSIZE_BYTE: return lanes_t'(4'b0001 << lo);
         HSIZE_HALF: return lo[1] ? 4'b1100 : 4'b0011;
         default:    return 4'b1111;               // Word and wider
      endcase
   endfunction

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};             // One step per bit
      end
   endtask

   task automatic flag_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      $display("CHECK FAILED: %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
   endtask

   task automatic end_test(input string name);
      $display("test %-8s %0d checks, %0d errors", name, checks - checks_mark,
               errors - errors_mark);
      checks_mark = checks;
      errors_mark = errors;
      tests_done++;
   endtask

   // ------------------------------------------------------------------------
   // Bus driver issues one address phase per call with write data a cycle later
   // ------------------------------------------------------------------------
   task automatic drive_cycle(input logic sel, input htrans_t trans, input logic wr,
                              input haddr_t addr, input hsize_t size, input data_t wdata);
      @(posedge HCLK);
      #DRIVE_DELAY;
      HWDATA = next_wdata;                         // Data phase of the last transfer
      HSEL   = sel;
      HTRANS = trans;
      HWRITE = wr;
      HADDR  = addr;
      HSIZE  = size;
      next_wdata = wdata;
   endtask

   task automatic write_xfer(input haddr_t addr, input hsize_t size, input data_t data);
      drive_cycle(1'b1, HTRANS_NONSEQ, 1'b1, addr, size, data);
   endtask

   task automatic read_xfer(input haddr_t addr);
      drive_cycle(1'b1, HTRANS_NONSEQ, 1'b0, addr, HSIZE_WORD, 32'hbad0_0bad);
   endtask

   task automatic idle_cycle();
      drive_cycle(1'b1, HTRANS_IDLE, 1'b0, 16'h0000, HSIZE_WORD, 32'h0);
   endtask

   // ------------------------------------------------------------------------
   // Monitor samples on the falling edge where everything is settled
   // ------------------------------------------------------------------------
   always @(negedge HCLK)
   begin : monitor
      logic  accept;
      logic  rd_now;
      data_t mask;

      accept = HSEL & HREADY & HTRANS[1];
      rd_now = accept & ~HWRITE;
      checks += 2;
      assert (HREADYOUT === 1'b1) else flag_mismatch("HREADYOUT", 32'(HREADYOUT), 32'h1);
      assert (HRESP === 1'b0) else flag_mismatch("HRESP", 32'(HRESP), 32'h0);
      if (!HRESETn)
      begin
         for (int i = 0; i < WORDS; i++)
            ref_mem[i] = u_sram.mem[i];            // Power-up fill of the RAM
         rd_dphase = 1'b0;
         wr_dphase = 1'b0;
         owe       = 1'b0;
         checks += 2;
         assert (SRAMCS === 1'b0) else flag_mismatch("SRAMCS", 32'(SRAMCS), 32'h0);
         assert (SRAMWEN === '0) else flag_mismatch("SRAMWEN", 32'(SRAMWEN), 32'h0);
      end
      else
      begin
         if (rd_dphase)
         begin
            checks++;
            assert (HRDATA === ref_mem[rd_addr])
               else flag_mismatch("HRDATA", HRDATA, ref_mem[rd_addr]);
         end
         if (wr_dphase)
         begin
            for (int i = 0; i < LANES; i++)
               if (wr_lanes[i])
                  ref_mem[wr_addr][8*i +: 8] = HWDATA[8*i +: 8];
            owe       = 1'b1;                      // RAM owes this write from now on
            owe_addr  = wr_addr;
            owe_lanes = wr_lanes;
            owe_data  = HWDATA;
         end
         if (rd_now)                               // Read takes the RAM port
         begin
            checks += 3;
            assert (SRAMCS === 1'b1) else flag_mismatch("SRAMCS", 32'(SRAMCS), 32'h1);
            assert (SRAMWEN === '0) else flag_mismatch("SRAMWEN", 32'(SRAMWEN), 32'h0);
            assert (SRAMADDR === HADDR[ADDR_W-1:2])
               else flag_mismatch("SRAMADDR", 32'(SRAMADDR), 32'(HADDR[ADDR_W-1:2]));
         end
         else if (owe)                             // First free cycle retires the write
         begin
            for (int i = 0; i < LANES; i++)
               mask[8*i +: 8] = {8{owe_lanes[i]}};
            checks += 4;
            assert (SRAMCS === 1'b1) else flag_mismatch("SRAMCS", 32'(SRAMCS), 32'h1);
            assert (SRAMWEN === owe_lanes)
               else flag_mismatch("SRAMWEN", 32'(SRAMWEN), 32'(owe_lanes));
            assert (SRAMADDR === owe_addr)
               else flag_mismatch("SRAMADDR", 32'(SRAMADDR), 32'(owe_addr));
            assert ((SRAMWDATA & mask) === (owe_data & mask))
               else flag_mismatch("SRAMWDATA", SRAMWDATA & mask, owe_data & mask);
            owe = 1'b0;
         end
         else
         begin
            checks += 2;
            assert (SRAMCS === 1'b0) else flag_mismatch("SRAMCS", 32'(SRAMCS), 32'h0);
            assert (SRAMWEN === '0) else flag_mismatch("SRAMWEN", 32'(SRAMWEN), 32'h0);
         end
         rd_dphase = rd_now;
         wr_dphase = accept & HWRITE;
         rd_addr   = HADDR[ADDR_W-1:2];
         wr_addr   = HADDR[ADDR_W-1:2];
         wr_lanes  = size_to_lanes(HSIZE, HADDR[1:0]);
      end
   end

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------
   task automatic run_random(input int n);
      logic [31:0] op, wsel, lo, sz, data;
      hsize_t      size;
      haddr_t      addr;

      for (int k = 0; k < n; k++)
      begin
         take_bits(3, op);
         take_bits(3, wsel);
         take_bits(2, lo);
         take_bits(2, sz);
         take_bits(32, data);
         size = (sz[1:0] == 2'd3) ? HSIZE_WORD : {1'b0, sz[1:0]};
         if (size == HSIZE_HALF)
            lo[0] = 1'b0;                          // Keep transfers aligned
         else if (size == HSIZE_WORD)
            lo[1:0] = 2'b00;
         addr = {RAND_BASE[ADDR_W-1:5], wsel[2:0], lo[1:0]};
         case (op[2:0])
            3'd0:       idle_cycle();
            3'd1:       drive_cycle(1'b0, HTRANS_NONSEQ, 1'b1, addr, size, data); // Not us
            3'd2, 3'd3,
            3'd4:       read_xfer(addr);
            default:    write_xfer(addr, size, data);
         endcase
      end
      repeat (3) idle_cycle();
   endtask

   initial
   begin
      HRESETn = 1'b0;
      HSEL    = 1'b0;
      HREADY  = 1'b1;
      HTRANS  = HTRANS_IDLE;
      HSIZE   = HSIZE_WORD;
      HWRITE  = 1'b0;
      HADDR   = '0;
      HWDATA  = '0;
      next_wdata = '0;
      lfsr_state = 32'h7eabccd9;
      errors      = 0;
      checks      = 0;
      checks_mark = 0;
      errors_mark = 0;
      tests_done  = 0;
      repeat (2) @(posedge HCLK);
      #DRIVE_DELAY HRESETn = 1'b1;

      // Reset and idle bus
      repeat (6) idle_cycle();
      end_test("idle");

      // Word write and a read back after the RAM has it
      write_xfer(16'h0040, HSIZE_WORD, 32'h1234_5678);
      repeat (3) idle_cycle();
      read_xfer(16'h0040);
      read_xfer(16'h0044);                         // Untouched word keeps the fill pattern
      repeat (2) idle_cycle();
      end_test("word");

      // Every byte and halfword alignment over known words
      write_xfer(16'h0090, HSIZE_WORD, 32'h1122_3344);
      write_xfer(16'h00a0, HSIZE_WORD, 32'h5566_7788);
      idle_cycle();
      for (int k = 0; k < 4; k++)
      begin
         write_xfer(haddr_t'(16'h0090 + k), HSIZE_BYTE, 32'h5a5a_5a5a ^ {4{8'(k)}});
         idle_cycle();
         read_xfer(16'h0090);
         idle_cycle();
      end
      for (int k = 0; k < 2; k++)
      begin
         write_xfer(haddr_t'(16'h00a0 + 2*k), HSIZE_HALF, 32'hc3d2_e1f0 + 32'(k));
         idle_cycle();
         read_xfer(16'h00a0);
         idle_cycle();
      end
      for (int k = 0; k < 4; k++)                  // Back to back bytes
         write_xfer(haddr_t'(16'h00b0 + k), HSIZE_BYTE, 32'h0f1e_2d3c << k);
      idle_cycle();
      read_xfer(16'h00b0);
      idle_cycle();
      end_test("lanes");

      // Reads right behind a write see it through the merge
      write_xfer(16'h00c0, HSIZE_WORD, 32'hcafe_0001);
      repeat (3) read_xfer(16'h00c0);
      idle_cycle();
      read_xfer(16'h00c0);
      write_xfer(16'h00c5, HSIZE_BYTE, 32'h0000_ee00);
      read_xfer(16'h00c4);
      read_xfer(16'h00c8);                         // Miss on the buffered word
      read_xfer(16'h00c4);
      idle_cycle();
      read_xfer(16'h00c4);
      write_xfer(16'h00ca, HSIZE_HALF, 32'hbeef_0000);
      read_xfer(16'h00c8);
      write_xfer(16'h00cc, HSIZE_WORD, 32'h600d_f00d);   // Retires the postponed write
      read_xfer(16'h00c8);
      read_xfer(16'h00cc);
      repeat (2) idle_cycle();
      end_test("merge");

      run_random(N_RANDOM);
      end_test("random");

      $display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // Watchdog sized from the cycle budgets above
   initial
   begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired before the tests completed");
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
hw/ahb_sram_pkg.sv
hw/ahb_byte_lanes.sv
hw/ahb_sram_ctrl.sv
hw/ahb_write_buffer.sv
hw/ahb_to_sram.sv
bench/sram_model.sv
bench/tb_ahb_to_sram.sv

/* hw/ahb_byte_lanes.sv */
`default_nettype none

// Address phase byte lane decode
// Byte picks one lane from the low address bits
// Halfword picks the lower or upper pair
// Word and anything wider picks all lanes
module ahb_byte_lanes
   import ahb_sram_pkg::*;
(
   input  wire hsize_t     hsize,     // Transfer size
   input  wire logic [1:0] addr_lo,   // Byte offset in the word
   output lanes_t          lanes      // Active lanes
);

   // -------------------------------------------------------------------------
   // Size decode
   // -------------------------------------------------------------------------
   logic is_byte;
   logic is_half;
   logic is_word;

   assign is_byte = (hsize == HSIZE_BYTE);
   assign is_half = (hsize == HSIZE_HALF);
   assign is_word = (hsize >= HSIZE_WORD);    // Wider sizes fold onto a full word

   // -------------------------------------------------------------------------
   // Lane select
   // -------------------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < LANES; i++)
      begin
         lanes[i] = is_word
                  | (is_half & (addr_lo[1] == i[1]))   // Pair 0-1 or 2-3
                  | (is_byte & (addr_lo == 2'(i)));    // Single lane
      end
   end

endmodule

`default_nettype wire

/* hw/ahb_sram_ctrl.sv */
`default_nettype none

// Access decode and RAM port control
// Reads use the RAM port in their address phase
// A buffered write waits for the first cycle without a read
module ahb_sram_ctrl
   import ahb_sram_pkg::*;
(
   input  wire logic       HCLK,
   input  wire logic       HRESETn,

   input  wire logic       HSEL,       // Slave select
   input  wire logic       HREADY,     // Previous transfer done
   input  wire logic       HWRITE,
   input  wire htrans_t    HTRANS,
   input  wire word_addr_t word_addr,  // HADDR without the byte offset

   input  wire word_addr_t buf_addr,   // Word held in the write buffer
   input  wire lanes_t     buf_lanes,  // Its valid lanes

   output logic            capture,    // Write address phase
   output logic            data_en,    // Write data phase
   output logic            pend,       // Buffered write still owed to RAM
   output logic            hit,        // Read addressed the buffered word

   output logic            SRAMCS,
   output lanes_t          SRAMWEN,
   output word_addr_t      SRAMADDR
);

   // -------------------------------------------------------------------------
   // Access decode
   // -------------------------------------------------------------------------
   logic active_trans;
   logic ahb_access;
   logic ahb_read;
   logic ahb_write;
   logic buf_busy;      // Buffer holds data not yet in RAM
   logic ram_write;
   logic pend_nxt;

   // Only NONSEQ and SEQ start an access
   assign active_trans = (HTRANS == HTRANS_NONSEQ) | (HTRANS == HTRANS_SEQ);
   assign ahb_access   = HSEL & HREADY & active_trans;
   assign ahb_read     = ahb_access & ~HWRITE;
   assign ahb_write    = ahb_access &  HWRITE;

   assign capture      = ahb_write;   // Buffer takes address and lanes now

   // -------------------------------------------------------------------------
   // Write sequencing
   // -------------------------------------------------------------------------

   // Data phase of a new write or an older one still waiting
   assign buf_busy  = pend | data_en;

   // The read owns the RAM port, so the write steps aside
   assign ram_write = buf_busy & ~ahb_read;
   assign pend_nxt  = buf_busy &  ahb_read;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         data_en <= 1'b0;
         pend    <= 1'b0;
      end
      else
      begin
         data_en <= ahb_write;   // Address phase to data phase
         pend    <= pend_nxt;
      end
   end

   // -------------------------------------------------------------------------
   // Read hit
   // -------------------------------------------------------------------------

   // Sampled only on reads and consumed in the read data phase
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
         hit <= 1'b0;
      else if (ahb_read)
         hit <= (word_addr == buf_addr);
   end

   // -------------------------------------------------------------------------
   // RAM port
   // -------------------------------------------------------------------------
   assign SRAMCS   = ahb_read | ram_write;
   assign SRAMWEN  = {LANES{ram_write}} & buf_lanes;   // Only the captured lanes
   assign SRAMADDR = ahb_read ? word_addr : buf_addr;  // Read address wins

endmodule

`default_nettype wire

/* hw/ahb_sram_pkg.sv */
`default_nettype none

package ahb_sram_pkg;

   // -------------------------------------------------------------------------
   // Widths
   // -------------------------------------------------------------------------
   localparam int ADDR_W      = 16;             // Bus byte address
   localparam int WORD_ADDR_W = ADDR_W - 2;     // RAM word address, 32-bit words
   localparam int DATA_W      = 32;             // Bus and RAM data
   localparam int LANES       = DATA_W / 8;     // One strobe per byte

   // -------------------------------------------------------------------------
   // Vector types
   // -------------------------------------------------------------------------
   typedef logic [ADDR_W-1:0]      haddr_t;     // Byte address on the bus
   typedef logic [WORD_ADDR_W-1:0] word_addr_t; // Word address on the RAM port
   typedef logic [DATA_W-1:0]      data_t;      // Data word
   typedef logic [LANES-1:0]       lanes_t;     // Byte lane mask, bit i is byte i
   typedef logic [1:0]             htrans_t;
   typedef logic [2:0]             hsize_t;

   // -------------------------------------------------------------------------
   // AHB encodings
   // -------------------------------------------------------------------------

   // Transfer type codes without BUSY, which this slave never decodes
   localparam htrans_t HTRANS_IDLE   = 2'b00;
   localparam htrans_t HTRANS_NONSEQ = 2'b10;
   localparam htrans_t HTRANS_SEQ    = 2'b11;

   // Transfer size
   localparam hsize_t HSIZE_BYTE = 3'b000;      // 8 bits
   localparam hsize_t HSIZE_HALF = 3'b001;      // 16 bits
   localparam hsize_t HSIZE_WORD = 3'b010;      // 32 bits

endpackage

`default_nettype wire

/* hw/ahb_to_sram.sv */
`default_nettype none

// AHB-Lite slave for a synchronous single-port RAM
// Zero wait states
// Writes go through a one-word buffer
module ahb_to_sram
   import ahb_sram_pkg::*;
(
   input  wire logic       HCLK,
   input  wire logic       HRESETn,

   // AHB-Lite slave port
   input  wire logic       HSEL,
   input  wire logic       HREADY,
   input  wire htrans_t    HTRANS,
   input  wire hsize_t     HSIZE,
   input  wire logic       HWRITE,
   input  wire haddr_t     HADDR,
   input  wire data_t      HWDATA,
   output logic            HREADYOUT,
   output logic            HRESP,
   output data_t           HRDATA,

   // RAM port
   input  wire data_t      SRAMRDATA,
   output word_addr_t      SRAMADDR,
   output lanes_t          SRAMWEN,     // Active high per byte
   output data_t           SRAMWDATA,
   output logic            SRAMCS       // Active high
);

   // -------------------------------------------------------------------------
   // Internal nets
   // -------------------------------------------------------------------------
   word_addr_t word_addr;
   logic [1:0] addr_lo;
   lanes_t     lanes;
   logic       capture;
   logic       data_en;
   logic       pend;
   logic       hit;
   word_addr_t buf_addr;
   lanes_t     buf_lanes;

   assign word_addr = HADDR[ADDR_W-1:2];
   assign addr_lo   = HADDR[1:0];

   // -------------------------------------------------------------------------
   // Blocks
   // -------------------------------------------------------------------------
   ahb_sram_ctrl u_ctrl (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .HSEL      (HSEL),
      .HREADY    (HREADY),
      .HWRITE    (HWRITE),
      .HTRANS    (HTRANS),
      .word_addr (word_addr),
      .buf_addr  (buf_addr),
      .buf_lanes (buf_lanes),
      .capture   (capture),
      .data_en   (data_en),
      .pend      (pend),
      .hit       (hit),
      .SRAMCS    (SRAMCS),
      .SRAMWEN   (SRAMWEN),
      .SRAMADDR  (SRAMADDR)
   );

   ahb_byte_lanes u_lanes (
      .hsize   (HSIZE),
      .addr_lo (addr_lo),
      .lanes   (lanes)
   );

   ahb_write_buffer u_buf (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .capture   (capture),
      .data_en   (data_en),
      .pend      (pend),
      .hit       (hit),
      .lanes     (lanes),
      .word_addr (word_addr),
      .HWDATA    (HWDATA),
      .SRAMRDATA (SRAMRDATA),
      .buf_addr  (buf_addr),
      .buf_lanes (buf_lanes),
      .SRAMWDATA (SRAMWDATA),
      .HRDATA    (HRDATA)
   );

   // No wait states and no error response
   assign HREADYOUT = 1'b1;
   assign HRESP     = 1'b0;    // OKAY

endmodule

`default_nettype wire

/* hw/ahb_write_buffer.sv */
`default_nettype none

// Single entry write buffer
// Address and lanes come from the address phase, data from the data phase
// Also patches read data with buffered bytes the RAM has not seen yet
module ahb_write_buffer
   import ahb_sram_pkg::*;
(
   input  wire logic       HCLK,
   input  wire logic       HRESETn,

   input  wire logic       capture,    // Write address phase
   input  wire logic       data_en,    // Write data phase
   input  wire logic       pend,       // RAM write postponed by a read
   input  wire logic       hit,        // Current read is to the buffered word

   input  wire lanes_t     lanes,      // Address phase strobes
   input  wire word_addr_t word_addr,  // Address phase word address
   input  wire data_t      HWDATA,
   input  wire data_t      SRAMRDATA,

   output word_addr_t      buf_addr,
   output lanes_t          buf_lanes,
   output data_t           SRAMWDATA,
   output data_t           HRDATA
);

   data_t  buf_data;   // Only lanes set in buf_lanes are meaningful
   lanes_t merge;

   // -------------------------------------------------------------------------
   // Address and lanes
   // -------------------------------------------------------------------------
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         buf_addr  <= '0;
         buf_lanes <= '0;
      end
      else if (capture)
      begin
         buf_addr  <= word_addr;
         buf_lanes <= lanes;
      end
   end

   // -------------------------------------------------------------------------
   // Data
   // -------------------------------------------------------------------------
   always_ff @(posedge HCLK)
   begin
      for (int i = 0; i < LANES; i++)
      begin
         if (data_en && buf_lanes[i])
            buf_data[8*i +: 8] <= HWDATA[8*i +: 8];   // Per lane load
      end
   end

   // Straight from the bus in the data phase, from the buffer once postponed
   assign SRAMWDATA = pend ? buf_data : HWDATA;

   // -------------------------------------------------------------------------
   // Read merge
   // -------------------------------------------------------------------------
   assign merge = {LANES{hit}} & buf_lanes;

   always_comb
   begin
      for (int i = 0; i < LANES; i++)
      begin
         if (merge[i])
            HRDATA[8*i +: 8] = buf_data[8*i +: 8];    // Newer than RAM
         else
            HRDATA[8*i +: 8] = SRAMRDATA[8*i +: 8];
      end
   end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the AHB to SRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_ahb_to_sram
OBJ=obj_dir

if ! verilator --binary --timing --assert -f compile.f --top-module "$TOP" -Mdir "$OBJ"; then
   echo "Verilator build failed"
   exit 1
fi

if ! OUT=$("./$OBJ/V$TOP"); then
   echo "$OUT"
   echo "Simulation exited with an error"
   exit 1
fi

echo "$OUT"

# Pass only when the testbench printed its pass line
if grep -qx "Testbench passed" <<< "$OUT"; then
   exit 0
fi
exit 1
